/* src.f */
video_pkg.sv
vram.sv
vram_arbiter.sv
video_timing.sv
tile_fetch.sv
pixel_shifter.sv
text_video_top.sv
tb_text_video.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it
# the run passes only if the log holds the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_text_video -o tb_text_video
./obj_dir/tb_text_video | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi

/* tb_text_video.sv */
// ==================================================
// testbench for the text video top with host port and frame checks
// assumes VRAM starts at zero
// never strobes the host port while busy
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module tb_text_video;
    import video_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int N_RANDOM     = 16;
    localparam int N_REWRITE    = 6;
    localparam int HOST_OPS     = 3 * N_RANDOM + (COLS * ROWS + N_REWRITE) * (1 + CELL_H / 2);
    // two frame waits per checked frame plus one to reach the display
    localparam int TIMEOUT      = 5 * FRAME_CYCLES + 12 * HOST_OPS + 1000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       host_wr;
    logic       host_rd;
    addr_t      host_addr;
    word_t      host_wdata;
    logic [3:0] host_mask;
    logic       host_busy;
    word_t      host_rdata;
    logic       host_rd_valid;
    color_t     color;
    logic       visible;
    logic       hsync;
    logic       vsync;

    word_t       shadow [0:65535];    // what the host has written
    logic [31:0] lfsr = 32'h9dc2_438d;
    int          check_errors = 0;
    int          other_errors = 0;
    int          frame_no = 0;
    int          frames_checked = 0;
    int          cycle_count = 0;
    logic        check_en = 1'b0;     // compare the current frame
    color_t      expected;
    logic        visible_q = 1'b0;
    logic        hsync_q = 1'b0;
    logic        vsync_q = 1'b0;
    int          x_pos, y_pos, frame_pixels, vis_lines;
    int          hsync_pulses, vsync_cycles, frame_cycles;

    always #2 clk = ~clk;

    text_video_top dut_i (
        .clk(clk), .rst_n(rst_n), .host_wr(host_wr), .host_rd(host_rd),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_mask(host_mask),
        .host_busy(host_busy), .host_rdata(host_rdata), .host_rd_valid(host_rd_valid),
        .color(color), .visible(visible), .hsync(hsync), .vsync(vsync)
    );

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic word_t apply_mask(input word_t old, input word_t data,
                                         input logic [3:0] mask);
        word_t bits;
        bits = {{4{mask[3]}}, {4{mask[2]}}, {4{mask[1]}}, {4{mask[0]}}};
        return (old & ~bits) | (data & bits);
    endfunction

    // expected pixel from the tile map and font in the shadow memory
    function automatic color_t pixel_ref(input int x, input int y);
        word_t      tile;
        word_t      font;
        logic [7:0] row_bits;
        int         line;
        line     = y % CELL_H;
        tile     = shadow[TILE_BASE + addr_t'((y / CELL_H) * COLS + x / CELL_W)];
        font     = shadow[FONT_BASE + addr_t'(int'(tile[7:0]) * (CELL_H / 2) + line / 2)];
        row_bits = (line % 2 == 1) ? font[7:0] : font[15:8];   // odd row in low byte
        return row_bits[3'(7 - x % CELL_W)] ? PALETTE[tile[15:12]] : PALETTE[tile[11:8]];
    endfunction

    task automatic wait_idle();
        @(negedge clk);
        while (host_busy) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic host_write(input addr_t addr, input word_t data, input logic [3:0] mask);
        int busy_cycles;
        wait_idle();
        host_wr    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        host_mask  <= mask;
        @(posedge clk);
        host_wr      <= 1'b0;
        shadow[addr] = apply_mask(shadow[addr], data, mask);
        busy_cycles  = 0;
        @(negedge clk);
        while (host_busy && busy_cycles < 8) begin
            busy_cycles++;
            @(negedge clk);
        end
        assert (busy_cycles >= 1 && busy_cycles <= 3) else begin
            other_errors++;
            $display("ERROR at %0t: write to %h held host_busy for %0d cycles",
                     $time, addr, busy_cycles);
        end
    endtask

    task automatic host_read(input addr_t addr, output word_t data);
        int waited;
        wait_idle();
        host_rd   <= 1'b1;
        host_addr <= addr;
        @(posedge clk);
        host_rd <= 1'b0;
        waited  = 0;
        @(negedge clk);
        while (!host_rd_valid && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        assert (host_rd_valid) else begin
            other_errors++;
            $display("ERROR at %0t: read of %h never returned data", $time, addr);
        end
        data = host_rdata;
    endtask

    task automatic write_then_read(input addr_t addr);
        word_t      data;
        word_t      got;
        logic [3:0] mask;
        data = word_t'(random_bits(16));
        mask = 4'(random_bits(4));
        host_write(addr, data, mask);
        host_read(addr, got);
        assert (got == shadow[addr]) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: read %h from %h, expected %h",
                     $time, got, addr, shadow[addr]);
        end
    endtask

    // random tile word followed by all glyph rows of its character
    task automatic write_cell(input int index);
        word_t tile;
        addr_t font;
        tile = word_t'(random_bits(16));
        host_write(TILE_BASE + addr_t'(index), tile, 4'hf);
        font = FONT_BASE + addr_t'(tile[7:0]) * addr_t'(CELL_H / 2);
        for (int r = 0; r < CELL_H / 2; r++) begin
            host_write(font + addr_t'(r), word_t'(random_bits(16)), 4'hf);
        end
    endtask

    // checks the frame after the next vsync with optional host traffic
    task automatic check_frame(input logic traffic);
        int start;
        start = frame_no;
        wait (frame_no == start + 1);
        check_en = 1'b1;
        while (traffic && frame_no == start + 1) begin
            write_then_read(16'h8000 | addr_t'(random_bits(12)));   // off screen
        end
        wait (frame_no == start + 2);
        check_en = 1'b0;
    endtask

    task automatic check_quiet_outputs(input string when_text);
        @(negedge clk);
        assert (!visible && !hsync && !vsync && !host_busy && !host_rd_valid && color == '0)
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: outputs not idle %s", $time, when_text);
        end
    endtask

    task automatic check_frame_counts();
        frames_checked++;
        assert (frame_pixels == H_VISIBLE * V_VISIBLE && vis_lines == V_VISIBLE) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: %0d pixels on %0d lines in frame",
                     $time, frame_pixels, vis_lines);
        end
        assert (hsync_pulses == V_TOTAL && frame_cycles == FRAME_CYCLES) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: %0d hsync pulses in %0d cycles",
                     $time, hsync_pulses, frame_cycles);
        end
        assert (vsync_cycles == H_TOTAL * (VSYNC_END - VSYNC_START)) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: vsync high for %0d cycles", $time, vsync_cycles);
        end
    endtask

    // the first visible pixel after a vsync rise is (0,0)
    always @(negedge clk) begin
        if (rst_n) begin
            assert (visible || color == '0) else begin
                check_errors++;
                $display("CHECK FAILED at %0t: color %h while not visible", $time, color);
            end
            if (vsync && !vsync_q) begin
                if (check_en) begin
                    check_frame_counts();
                end
                frame_no++;
                x_pos        = 0;
                y_pos        = 0;
                frame_pixels = 0;
                vis_lines    = 0;
                hsync_pulses = 0;
                vsync_cycles = 0;
                frame_cycles = 0;
            end
            if (visible) begin
                if (check_en) begin
                    expected = pixel_ref(x_pos, y_pos);
                    assert (color == expected) else begin
                        check_errors++;
                        $display("CHECK FAILED at %0t: pixel (%0d,%0d) is %h, expected %h",
                                 $time, x_pos, y_pos, color, expected);
                    end
                end
                x_pos++;
                frame_pixels++;
            end else if (visible_q) begin
                if (check_en) begin
                    assert (x_pos == H_VISIBLE) else begin
                        check_errors++;
                        $display("CHECK FAILED at %0t: line %0d has %0d pixels",
                                 $time, y_pos, x_pos);
                    end
                end
                x_pos = 0;
                y_pos++;
                vis_lines++;
            end
            if (hsync && !hsync_q) hsync_pulses++;
            if (vsync) vsync_cycles++;
            frame_cycles++;
            visible_q = visible;
            hsync_q   = hsync;
            vsync_q   = vsync;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
        $display("errors: %0d check failures, %0d other failures, %0d frames checked",
                 check_errors, other_errors, frames_checked);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        addr_t rand_addr;
        rst_n      = 1'b0;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_mask  = '0;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = '0;
        end

        // reset and idle outputs
        repeat (7) @(posedge clk);
        check_quiet_outputs("during reset");
        @(posedge clk);
        rst_n <= 1'b1;
        check_quiet_outputs("after reset release");
        repeat (16) begin
            @(negedge clk);
            assert (!host_busy && !host_rd_valid) else begin
                check_errors++;
                $display("CHECK FAILED at %0t: host port active without a request", $time);
            end
        end

        // masked writes and read-back at random addresses
        repeat (N_RANDOM) begin
            rand_addr = addr_t'(random_bits(16));
            host_write(rand_addr, word_t'(random_bits(16)), 4'hf);   // nonzero old word
            write_then_read(rand_addr);
        end

        // full screen followed by one checked frame with sync counts
        for (int i = 0; i < COLS * ROWS; i++) begin
            write_cell(i);
        end
        check_frame(1'b0);

        // tile rewrites during display and the next frame checked under traffic
        @(negedge clk);
        while (!visible) @(negedge clk);
        repeat (N_REWRITE) begin
            write_cell(int'(random_bits(5)));
        end
        check_frame(1'b1);

        assert (frames_checked == 2) else begin
            other_errors++;
            $display("ERROR: %0d frames were checked instead of 2", frames_checked);
        end
        $display("errors: %0d check failures, %0d other failures, %0d frames checked",
                 check_errors, other_errors, frames_checked);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* text_video_top.sv */
// ==================================================
// text mode video top, timing to fetch to shifter
// host port shares the VRAM through fixed slots
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module text_video_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             host_wr,
    input  wire logic             host_rd,
    input  wire video_pkg::addr_t host_addr,
    input  wire video_pkg::word_t host_wdata,
    input  wire logic [3:0]       host_mask,
    output logic                  host_busy,
    output video_pkg::word_t      host_rdata,
    output logic                  host_rd_valid,
    output video_pkg::color_t     color,
    output logic                  visible,
    output logic                  hsync,
    output logic                  vsync
);
    import video_pkg::*;

    logic [2:0] cell_phase;
    logic [2:0] fetch_col;
    logic [4:0] fetch_line;
    logic       fetch_active;
    logic       tm_visible;      // undelayed timing levels
    logic       tm_hsync;
    logic       tm_vsync;
    logic       vid_req;
    addr_t      vid_addr;
    word_t      vid_rdata;
    logic       load;
    logic [7:0] glyph;
    logic [3:0] fg_idx;
    logic [3:0] bg_idx;
    logic       mem_sel;
    logic       mem_wr;
    logic [3:0] mem_mask;
    addr_t      mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;

    video_timing timing_i (
        .clk(clk), .rst_n(rst_n), .h_count(), .v_count(),
        .cell_phase(cell_phase), .fetch_col(fetch_col), .fetch_line(fetch_line),
        .fetch_active(fetch_active), .visible(tm_visible),
        .hsync(tm_hsync), .vsync(tm_vsync)
    );

    tile_fetch fetch_i (
        .clk(clk), .rst_n(rst_n), .cell_phase(cell_phase),
        .fetch_col(fetch_col), .fetch_line(fetch_line), .fetch_active(fetch_active),
        .vid_req(vid_req), .vid_addr(vid_addr), .vid_rdata(vid_rdata),
        .load(load), .glyph(glyph), .fg_idx(fg_idx), .bg_idx(bg_idx)
    );

    vram_arbiter arb_i (
        .clk(clk), .rst_n(rst_n), .cell_phase(cell_phase),
        .vid_req(vid_req), .vid_addr(vid_addr), .vid_rdata(vid_rdata),
        .host_wr(host_wr), .host_rd(host_rd), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_mask(host_mask), .host_busy(host_busy),
        .host_rdata(host_rdata), .host_rd_valid(host_rd_valid),
        .mem_sel(mem_sel), .mem_wr(mem_wr), .mem_mask(mem_mask),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    vram vram_i (
        .clk(clk), .sel(mem_sel), .wr_en(mem_wr), .wr_mask(mem_mask),
        .address_in(mem_addr), .data_in(mem_wdata), .data_out(mem_rdata)
    );

    pixel_shifter shifter_i (
        .clk(clk), .rst_n(rst_n), .load(load), .glyph(glyph),
        .fg_idx(fg_idx), .bg_idx(bg_idx), .visible_in(tm_visible),
        .hsync_in(tm_hsync), .vsync_in(tm_vsync), .color(color),
        .visible(visible), .hsync(hsync), .vsync(vsync)
    );

endmodule

`default_nettype wire

/* pixel_shifter.sv */
// ==================================================
// glyph shift register and palette lookup, msb first
// one register stage, sync levels delayed to match
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module pixel_shifter (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       load,
    input  wire logic [7:0] glyph,
    input  wire logic [3:0] fg_idx,
    input  wire logic [3:0] bg_idx,
    input  wire logic       visible_in,
    input  wire logic       hsync_in,
    input  wire logic       vsync_in,
    output video_pkg::color_t color,
    output logic            visible,
    output logic            hsync,
    output logic            vsync
);
    import video_pkg::*;

    logic [7:0] shift_q;
    logic [3:0] fg_q;
    logic [3:0] bg_q;
    color_t     pix;

    // bit 7 is the current pixel
    assign pix = shift_q[7] ? PALETTE[fg_q] : PALETTE[bg_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;
            fg_q    <= '0;
            bg_q    <= '0;
            color   <= '0;
            visible <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
        end else begin
            if (load) begin
                shift_q <= glyph;
                fg_q    <= fg_idx;
                bg_q    <= bg_idx;
            end else begin
                shift_q <= {shift_q[6:0], 1'b0};
            end
            color   <= visible_in ? pix : '0;   // black in blanking
            visible <= visible_in;
            hsync   <= hsync_in;
            vsync   <= vsync_in;
        end
    end

endmodule

`default_nettype wire

/* tile_fetch.sv */
// ==================================================
// per cell: tile read at phase 0, font read at phase 2
// load pulses at phase 7 with glyph row and colours
// inactive cells hand on a blank glyph
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module tile_fetch (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [2:0]       cell_phase,
    input  wire logic [2:0]       fetch_col,
    input  wire logic [4:0]       fetch_line,
    input  wire logic             fetch_active,
    output logic                  vid_req,
    output video_pkg::addr_t      vid_addr,
    input  wire video_pkg::word_t vid_rdata,
    output logic                  load,
    output logic [7:0]            glyph,
    output logic [3:0]            fg_idx,
    output logic [3:0]            bg_idx
);
    import video_pkg::*;

    word_t      tile_q;       // fg, bg, char of the cell being fetched
    logic [2:0] cell_line;    // line within the glyph
    addr_t      tile_addr;
    addr_t      font_addr;

    assign cell_line = fetch_line[2:0];

    assign tile_addr = TILE_BASE
                     + addr_t'(fetch_line / CELL_H) * addr_t'(COLS)
                     + addr_t'(fetch_col);
    assign font_addr = FONT_BASE
                     + addr_t'(tile_q[7:0]) * addr_t'(GLYPH_WORDS)
                     + addr_t'(cell_line >> 1);

    always_comb begin
        vid_req  = 1'b0;
        vid_addr = tile_addr;
        if (fetch_active) begin
            if (cell_phase == 3'd0) begin
                vid_req = 1'b1;
            end else if (cell_phase == 3'd2) begin
                vid_req  = 1'b1;
                vid_addr = font_addr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load <= 1'b0;
        end else begin
            load <= (cell_phase == 3'd6);   // high during phase 7
        end
    end

    // tile word arrives at phase 1, font word at phase 3
    always_ff @(posedge clk) begin
        if (cell_phase == 3'd1) begin
            tile_q <= fetch_active ? vid_rdata : '0;
        end
        if (cell_phase == 3'd3) begin
            if (!fetch_active) begin
                glyph <= 8'h00;
            end else if (cell_line[0]) begin
                glyph <= vid_rdata[7:0];    // odd row in low byte
            end else begin
                glyph <= vid_rdata[15:8];
            end
            fg_idx <= tile_q[15:12];
            bg_idx <= tile_q[11:8];
        end
    end

endmodule

`default_nettype wire

/* video_timing.sv */
// ==================================================
// pixel and line counters, one pixel per clock
// sync pulses are active high
// fetch position runs one cell ahead of the display
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module video_timing (
    input  wire logic  clk,
    input  wire logic  rst_n,
    output logic [6:0] h_count,
    output logic [5:0] v_count,
    output logic [2:0] cell_phase,
    output logic [2:0] fetch_col,
    output logic [4:0] fetch_line,
    output logic       fetch_active,
    output logic       visible,
    output logic       hsync,
    output logic       vsync
);
    import video_pkg::*;

    logic [3:0] h_cell;
    logic [3:0] next_cell;
    logic       wrap;        // next cell is on the next line
    logic [5:0] next_line;
    logic [5:0] line_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == 7'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == 6'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 6'd1;
            end
        end else begin
            h_count <= h_count + 7'd1;
        end
    end

    assign cell_phase = h_count[2:0];
    assign visible    = (h_count < 7'(H_VISIBLE)) && (v_count < 6'(V_VISIBLE));
    assign hsync      = (h_count >= 7'(HSYNC_START)) && (h_count < 7'(HSYNC_END));
    assign vsync      = (v_count >= 6'(VSYNC_START)) && (v_count < 6'(VSYNC_END));

    // look-ahead cell, last blank cell fetches column 0 of the next line
    assign h_cell    = h_count[6:3];
    assign next_cell = h_cell + 4'd1;
    assign wrap      = (next_cell == 4'(H_TOTAL / CELL_W));
    assign next_line = (v_count == 6'(V_TOTAL - 1)) ? '0 : v_count + 6'd1;
    assign line_sel  = wrap ? next_line : v_count;

    assign fetch_col    = wrap ? 3'd0 : next_cell[2:0];
    assign fetch_line   = line_sel[4:0];
    assign fetch_active = (wrap || (next_cell < 4'(COLS))) &&
                          (line_sel < 6'(V_VISIBLE));

endmodule

`default_nettype wire

/* vram_arbiter.sv */
// ==================================================
// fixed slot VRAM sharing, video owns phases 0 and 2
// one host request pending at a time, strobe only
// while host_busy is low
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [2:0]       cell_phase,
    input  wire logic             vid_req,
    input  wire video_pkg::addr_t vid_addr,
    output video_pkg::word_t      vid_rdata,
    input  wire logic             host_wr,
    input  wire logic             host_rd,
    input  wire video_pkg::addr_t host_addr,
    input  wire video_pkg::word_t host_wdata,
    input  wire logic [3:0]       host_mask,
    output logic                  host_busy,
    output video_pkg::word_t      host_rdata,
    output logic                  host_rd_valid,
    output logic                  mem_sel,
    output logic                  mem_wr,
    output logic [3:0]            mem_mask,
    output video_pkg::addr_t      mem_addr,
    output video_pkg::word_t      mem_wdata,
    input  wire video_pkg::word_t mem_rdata
);
    import video_pkg::*;

    logic       vid_slot;
    logic       host_go;
    logic       pend_valid;
    logic       pend_wr;
    addr_t      pend_addr;
    word_t      pend_wdata;
    logic [3:0] pend_mask;
    logic       last_vid;    // previous access was a video fetch

    assign vid_slot  = HOST_SLOT_MASK[cell_phase];
    assign host_go   = pend_valid && !vid_slot;   // first host slot after capture
    assign host_busy = pend_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid    <= 1'b0;
            last_vid      <= 1'b0;
            host_rd_valid <= 1'b0;
        end else begin
            if (host_go) begin
                pend_valid <= 1'b0;
            end else if (host_wr || host_rd) begin
                pend_valid <= 1'b1;
            end
            last_vid      <= vid_slot && vid_req;
            host_rd_valid <= host_go && !pend_wr;
        end
    end

    // request payload, held until the host slot
    always_ff @(posedge clk) begin
        if (!pend_valid && (host_wr || host_rd)) begin
            pend_wr    <= host_wr;
            pend_addr  <= host_addr;
            pend_wdata <= host_wdata;
            pend_mask  <= host_mask;
        end
    end

    always_comb begin
        if (vid_slot) begin
            mem_sel  = vid_req;
            mem_wr   = 1'b0;
            mem_mask = 4'h0;
            mem_addr = vid_addr;
        end else begin
            mem_sel  = host_go;
            mem_wr   = pend_wr;
            mem_mask = pend_mask;
            mem_addr = pend_addr;
        end
    end

    assign mem_wdata = pend_wdata;   // only written in host slots

    // read data goes to whoever owned the last cycle
    assign vid_rdata  = last_vid ? mem_rdata : '0;
    assign host_rdata = host_rd_valid ? mem_rdata : '0;

endmodule

`default_nettype wire

/* vram.sv */
// ==================================================
// behavioural 64K x 16 video RAM, one port
// registered read returns the old word on a write
// no reset, contents start at zero
// ==================================================
`default_nettype none
`timescale 1ns/1ps

module vram (
    input  wire logic             clk,
    input  wire logic             sel,
    input  wire logic             wr_en,
    input  wire logic [3:0]       wr_mask,     // one bit per nibble
    input  wire video_pkg::addr_t address_in,
    input  wire video_pkg::word_t data_in,
    output video_pkg::word_t      data_out
);
    import video_pkg::*;

    word_t mem [0:65535];

    // simulation starts from a clean memory
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            if (wr_en) begin
                if (wr_mask[0]) mem[address_in][3:0]   <= data_in[3:0];
                if (wr_mask[1]) mem[address_in][7:4]   <= data_in[7:4];
                if (wr_mask[2]) mem[address_in][11:8]  <= data_in[11:8];
                if (wr_mask[3]) mem[address_in][15:12] <= data_in[15:12];
            end
            data_out <= mem[address_in];   // read before write
        end
    end

endmodule

`default_nettype wire

/* video_pkg.sv */
// ==================================================
// shared types, screen geometry, VRAM map and palette
// cell logic assumes CELL_W and CELL_H of 8
// ==================================================
`default_nettype none

package video_pkg;

    typedef logic [15:0] addr_t;     // VRAM word address
    typedef logic [15:0] word_t;     // VRAM data word
    typedef logic [11:0] color_t;    // 4:4:4 RGB

    // horizontal timing in pixels
    localparam int H_VISIBLE   = 64;
    localparam int H_TOTAL     = 80;
    localparam int HSYNC_START = 68;
    localparam int HSYNC_END   = 72;

    // vertical timing in lines
    localparam int V_VISIBLE   = 32;
    localparam int V_TOTAL     = 36;
    localparam int VSYNC_START = 33;
    localparam int VSYNC_END   = 34;

    // character cells
    localparam int CELL_W      = 8;
    localparam int CELL_H      = 8;
    localparam int COLS        = 8;
    localparam int ROWS        = 4;
    localparam int GLYPH_WORDS = CELL_H / 2;   // two glyph rows per font word

    // memory map
    localparam addr_t TILE_BASE = 16'h0000;
    localparam addr_t FONT_BASE = 16'hf000;

    // set bit = phase reserved for video fetch, all others go to the host
    localparam logic [7:0] HOST_SLOT_MASK = 8'b0000_0101;

    // fixed 16 colour table
    localparam color_t PALETTE [16] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa,
        12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff,
        12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

endpackage

`default_nettype wire
